//--- verilog/ppu_cfg_pkg.sv
// PPU configuration definitions
package ppu_cfg_pkg;

  // Output resolution as chosen in the menu
  typedef enum logic [2:0] {
    TGT_480P  = 3'd0,
    TGT_720P  = 3'd1,
    TGT_960P  = 3'd2,
    TGT_1080P = 3'd3,
    TGT_1200P = 3'd4
  } target_res_e;

  // Output video timing actually driven to the HDMI transmitter
  typedef enum logic [3:0] {
    VM_480P60  = 4'd0,
    VM_VGA60   = 4'd1,
    VM_720P60  = 4'd2,
    VM_960P60  = 4'd3,
    VM_1080P60 = 4'd4,
    VM_1200P60 = 4'd5,
    VM_576P50  = 4'd6,
    VM_720P50  = 4'd7,
    VM_960P50  = 4'd8,
    VM_1080P50 = 4'd9,
    VM_1200P50 = 4'd10
  } video_mode_e;

  // Configuration word, MSB first
  typedef struct packed {
    logic        limited_rgb;   // 16..235 output range
    logic        force60;
    logic        force50;
    logic        llm;           // Low latency mode
    logic        vga480p;       // VGA timing instead of 480p
    target_res_e target_res;
    logic        link_hv;       // Horizontal factor follows vertical
    logic [4:0]  vscale;
    logic [4:0]  hscale;
    logic [1:0]  interp;
    logic        pal_boxed;
    logic        sl240_en;
    logic        sl240_id;
    logic        sl240_method;
    logic [3:0]  sl240_str;
    logic [4:0]  sl240_hyb;
    logic        sl480_en;
    logic        sl480_id;
    logic        sl480_linked;  // 480i scanlines copy the 240p ones
    logic [3:0]  sl480_str;
    logic [4:0]  sl480_hyb;
  } cfg_word_t;

  // OSD window placement per output mode
  typedef struct packed {
    logic [2:0]  vscale;
    logic [1:0]  hscale;
    logic [10:0] voffset;
    logic [11:0] hoffset;
    logic        active_vsync;
    logic        active_hsync;
  } osd_place_t;

  localparam logic SYNC_SD = 1'b0;  // SD modes use negative syncs
  localparam logic SYNC_HD = 1'b1;  // HD modes use positive syncs

  // ==============================
  // vscale  hscale  voffset  hoffset  vsync  hsync
  localparam osd_place_t OSD_480P60  = '{3'd1, 2'd0, 11'd60, 12'd266, SYNC_SD, SYNC_SD};
  localparam osd_place_t OSD_VGA60   = '{3'd1, 2'd0, 11'd59, 12'd248, SYNC_SD, SYNC_SD};
  localparam osd_place_t OSD_576P50  = '{3'd1, 2'd0, 11'd88, 12'd276, SYNC_SD, SYNC_SD};
  localparam osd_place_t OSD_720P    = '{3'd2, 2'd1, 11'd50, 12'd234, SYNC_HD, SYNC_HD};
  localparam osd_place_t OSD_960P    = '{3'd3, 2'd1, 11'd48, 12'd160, SYNC_HD, SYNC_HD};
  localparam osd_place_t OSD_1080P60 = '{3'd4, 2'd2, 11'd38, 12'd168, SYNC_HD, SYNC_HD};
  localparam osd_place_t OSD_1080P50 = '{3'd3, 2'd2, 11'd67, 12'd168, SYNC_HD, SYNC_HD};
  localparam osd_place_t OSD_1200P   = '{3'd4, 2'd2, 11'd48, 12'd88,  SYNC_HD, SYNC_HD};

  // Scanline thickness steps over vscale
  localparam logic [4:0] SL_THICK_LIM1 = 5'd6;   // Below 3.5x
  localparam logic [4:0] SL_THICK_LIM2 = 5'd14;  // Below 5.5x

endpackage

//--- verilog/ppu_video_pkg.sv
// PPU video stream definitions
package ppu_video_pkg;

  localparam int unsigned COLOR_W = 8;  // Bits per colour channel

  // RGB pixel, red in the upper bits
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } pixel_t;

  // Sync and data enable travel together
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } sync_t;

  // ==============================
  // Limited range, c * 220/256 + 16
  localparam logic [COLOR_W-1:0] LIMIT_COEFF      = 8'd220;
  localparam logic [3:0]         LIMIT_OFFSET_NIB = 4'd1;  // +16 in upper nibble

  // Latency of the range limiter, matched by the delay lines
  localparam int unsigned PIPE_DEPTH = 2;

endpackage

//--- verilog/ppu_cfg_decode.sv
// Output mode and setting decode
`timescale 1ns/1ps

module ppu_cfg_decode (
  input  logic                     VCLK_Tx,
  input  logic                     nVRST_Tx,
  input  ppu_cfg_pkg::cfg_word_t   cfg_word_i,
  input  logic                     vinfo_pal_i,
  input  logic                     vinfo_480i_i,
  output ppu_cfg_pkg::video_mode_e video_mode_o,
  output logic [2:0]               osd_vscale_o,
  output logic [1:0]               osd_hscale_o,
  output logic [10:0]              osd_voffset_o,
  output logic [11:0]              osd_hoffset_o,
  output logic                     active_vsync_o,
  output logic                     active_hsync_o,
  output logic [4:0]               vscale_o,
  output logic [4:0]               hscale_o,
  output logic [1:0]               interp_o,
  output logic                     pal_boxed_o,
  output logic                     llm_o,
  output logic                     limited_rgb_o,
  output logic [7:0]               sl_str_o,
  output logic [4:0]               sl_hyb_o,
  output logic [1:0]               sl_thickness_o,
  output logic                     sl_id_o,
  output logic                     sl_en_o,
  output logic                     sl_method_o
);

  import ppu_cfg_pkg::*;

  video_mode_e mode_60, mode_50, mode_nxt;
  logic        use_50;
  logic [3:0]  sl_str_sel;
  logic [4:0]  sl_hyb_nxt;
  logic        sl_id_nxt, sl_en_nxt, sl_method_nxt;
  osd_place_t  osd_nxt;

  // First register stage, straight from the config word
  video_mode_e video_mode_q;
  logic [4:0]  vscale_q, hscale_q;
  logic [1:0]  interp_q;
  logic        pal_boxed_q, llm_q, limited_rgb_q;
  logic [7:0]  sl_str_q;
  logic [4:0]  sl_hyb_q;
  logic        sl_id_q, sl_en_q, sl_method_q;

  // Second stage, derived from registered mode and vscale
  osd_place_t  osd_q;
  logic [1:0]  sl_thickness_q;

  // ==============================
  // Mode selection
  always_comb begin
    unique case (cfg_word_i.target_res)
      TGT_1200P: mode_60 = VM_1200P60;
      TGT_1080P: mode_60 = VM_1080P60;
      TGT_960P:  mode_60 = VM_960P60;
      TGT_720P:  mode_60 = VM_720P60;
      default:   mode_60 = cfg_word_i.vga480p ? VM_VGA60 : VM_480P60;  // VGA only at 60 Hz
    endcase
    unique case (cfg_word_i.target_res)
      TGT_1200P: mode_50 = VM_1200P50;
      TGT_1080P: mode_50 = VM_1080P50;
      TGT_960P:  mode_50 = VM_960P50;
      TGT_720P:  mode_50 = VM_720P50;
      default:   mode_50 = VM_576P50;
    endcase
    // Forcing a rate is not allowed in low latency mode
    if (cfg_word_i.force60 && !cfg_word_i.llm)
      use_50 = 1'b0;
    else if (cfg_word_i.force50 && !cfg_word_i.llm)
      use_50 = 1'b1;
    else
      use_50 = vinfo_pal_i;  // Follow the console
    mode_nxt = use_50 ? mode_50 : mode_60;
  end

  // Scanline source, 240p set or 480i set
  always_comb begin
    if (!vinfo_480i_i) begin
      sl_str_sel    = cfg_word_i.sl240_str;
      sl_hyb_nxt    = cfg_word_i.sl240_hyb;
      sl_id_nxt     = cfg_word_i.sl240_id;
      sl_method_nxt = cfg_word_i.sl240_method;
      sl_en_nxt     = cfg_word_i.sl240_en;
    end else begin
      if (cfg_word_i.sl480_linked) begin  // Borrow the 240p look
        sl_str_sel = cfg_word_i.sl240_str;
        sl_hyb_nxt = cfg_word_i.sl240_hyb;
        sl_id_nxt  = cfg_word_i.sl240_id;
      end else begin
        sl_str_sel = cfg_word_i.sl480_str;
        sl_hyb_nxt = cfg_word_i.sl480_hyb;
        sl_id_nxt  = cfg_word_i.sl480_id;
      end
      sl_method_nxt = 1'b0;  // No alternative method for interlaced
      sl_en_nxt     = cfg_word_i.sl480_en;
    end
  end

  // OSD placement from the registered mode
  always_comb begin
    unique case (video_mode_q)
      VM_VGA60:              osd_nxt = OSD_VGA60;
      VM_720P60, VM_720P50:  osd_nxt = OSD_720P;
      VM_960P60, VM_960P50:  osd_nxt = OSD_960P;
      VM_1080P60:            osd_nxt = OSD_1080P60;
      VM_1080P50:            osd_nxt = OSD_1080P50;
      VM_1200P60, VM_1200P50: osd_nxt = OSD_1200P;
      VM_576P50:             osd_nxt = OSD_576P50;
      default:               osd_nxt = OSD_480P60;
    endcase
  end

  // ==============================
  // Setting registers
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      video_mode_q   <= VM_480P60;
      vscale_q       <= '0;
      hscale_q       <= '0;
      interp_q       <= '0;
      pal_boxed_q    <= 1'b0;
      llm_q          <= 1'b0;
      limited_rgb_q  <= 1'b0;
      sl_str_q       <= '0;
      sl_hyb_q       <= '0;
      sl_id_q        <= 1'b0;
      sl_en_q        <= 1'b0;
      sl_method_q    <= 1'b0;
      osd_q          <= '0;
      sl_thickness_q <= '0;
    end else begin
      video_mode_q  <= mode_nxt;
      vscale_q      <= cfg_word_i.vscale;
      hscale_q      <= cfg_word_i.link_hv ? cfg_word_i.vscale : cfg_word_i.hscale;
      interp_q      <= cfg_word_i.interp;
      pal_boxed_q   <= cfg_word_i.pal_boxed;
      llm_q         <= cfg_word_i.llm;
      limited_rgb_q <= cfg_word_i.limited_rgb;
      sl_str_q      <= {sl_str_sel, 4'hF};  // (str+1)*16-1
      sl_hyb_q      <= sl_hyb_nxt;
      sl_id_q       <= sl_id_nxt;
      sl_en_q       <= sl_en_nxt;
      sl_method_q   <= sl_method_nxt;
      osd_q         <= osd_nxt;
      if (vscale_q < SL_THICK_LIM1)
        sl_thickness_q <= 2'd0;
      else if (vscale_q < SL_THICK_LIM2)
        sl_thickness_q <= 2'd1;
      else
        sl_thickness_q <= 2'd2;
    end
  end

  assign video_mode_o   = video_mode_q;
  assign osd_vscale_o   = osd_q.vscale;
  assign osd_hscale_o   = osd_q.hscale;
  assign osd_voffset_o  = osd_q.voffset;
  assign osd_hoffset_o  = osd_q.hoffset;
  assign active_vsync_o = osd_q.active_vsync;
  assign active_hsync_o = osd_q.active_hsync;
  assign vscale_o       = vscale_q;
  assign hscale_o       = hscale_q;
  assign interp_o       = interp_q;
  assign pal_boxed_o    = pal_boxed_q;
  assign llm_o          = llm_q;
  assign limited_rgb_o  = limited_rgb_q;
  assign sl_str_o       = sl_str_q;
  assign sl_hyb_o       = sl_hyb_q;
  assign sl_thickness_o = sl_thickness_q;
  assign sl_id_o        = sl_id_q;
  assign sl_en_o        = sl_en_q;
  assign sl_method_o    = sl_method_q;

  // Scaler and OSD only know the listed timings
  a_mode_defined: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    !$isunknown(video_mode_q) && (video_mode_q <= VM_1200P50))
    else $error("video mode out of range");

endmodule

//--- verilog/rgb_range_limit.sv
// Limited range RGB compression
`timescale 1ns/1ps

module rgb_range_limit (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  ppu_video_pkg::pixel_t pixel_i,
  output ppu_video_pkg::pixel_t pixel_o
);

  import ppu_video_pkg::*;

  // Legal output window, 16..235
  localparam logic [COLOR_W-1:0] CH_MIN = {LIMIT_OFFSET_NIB, 4'h0};
  localparam logic [COLOR_W-1:0] CH_MAX = CH_MIN + LIMIT_COEFF - 8'd1;

  logic [2:0][COLOR_W-1:0]   chan_in;   // [2] red .. [0] blue
  logic [2:0][2*COLOR_W-1:0] prod;
  logic [2:0][COLOR_W:0]     scaled_q;  // Product bits 15:7
  logic [2:0][COLOR_W-1:0]   rnd;
  logic [2:0][COLOR_W-1:0]   limited_q;

  assign chan_in = pixel_i;

  // ==============================
  // Multiply and round
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      prod[c] = {{COLOR_W{1'b0}}, chan_in[c]} * {{COLOR_W{1'b0}}, LIMIT_COEFF};
      // Half LSB kept in bit 0 rounds up
      rnd[c]  = scaled_q[c][COLOR_W:1] + {{(COLOR_W-1){1'b0}}, scaled_q[c][0]};
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_q  <= '0;
      limited_q <= '0;
    end else begin
      for (int c = 0; c < 3; c++) begin
        scaled_q[c]  <= prod[c][2*COLOR_W-1:COLOR_W-1];  // Stage 1
        limited_q[c] <= {rnd[c][COLOR_W-1:4] + LIMIT_OFFSET_NIB, rnd[c][3:0]};  // Stage 2
      end
    end
  end

  assign pixel_o = limited_q;

  // Both stages must have seen real data before the window holds
  for (genvar c = 0; c < 3; c++) begin : g_range_chk
    a_in_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(nVRST_Tx) |-> (limited_q[c] >= CH_MIN) && (limited_q[c] <= CH_MAX))
      else $error("limited channel %0d out of range", c);
  end

endmodule

//--- verilog/video_delay_line.sv
// Fixed depth video delay
`timescale 1ns/1ps

module video_delay_line #(
  parameter int unsigned DEPTH = 2,  // Cycles of delay
  parameter type payload_t = logic
) (
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t pipe_q [DEPTH];  // [0] newest

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < DEPTH; i++) begin
        pipe_q[i] <= '0;
      end
    end else begin
      pipe_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        pipe_q[i] <= pipe_q[i-1];  // Shift one slot per clock
      end
    end
  end

  assign data_o = pipe_q[DEPTH-1];

endmodule

//--- verilog/ppu_output_stage.sv
// Final video output register
`timescale 1ns/1ps

module ppu_output_stage (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic                  limited_rgb_i,
  input  ppu_video_pkg::pixel_t limited_i,
  input  ppu_video_pkg::pixel_t full_i,
  input  ppu_video_pkg::sync_t  sync_i,
  output logic                  vsync_o,
  output logic                  hsync_o,
  output logic                  de_o,
  output ppu_video_pkg::pixel_t vdata_o
);

  // Output flops sit next to the transmitter pins
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vsync_o <= 1'b0;
      hsync_o <= 1'b0;
      de_o    <= 1'b0;
      vdata_o <= '0;
    end else begin
      vsync_o <= sync_i.vsync;
      hsync_o <= sync_i.hsync;
      de_o    <= sync_i.de;
      if (limited_rgb_i)
        vdata_o <= limited_i;  // 16..235
      else
        vdata_o <= full_i;     // 0..255 pass through
    end
  end

  // The sync delay line comes out of reset empty as well
  a_de_quiet: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $rose(nVRST_Tx) |=> !de_o)
    else $error("data enable active right after reset");

endmodule

//--- verilog/ppu_tx_top.sv
// PPU transmit side top level
`timescale 1ns/1ps

module ppu_tx_top #(
  parameter int unsigned PIPE_DEPTH = ppu_video_pkg::PIPE_DEPTH
) (
  input  logic                     VCLK_Tx,
  input  logic                     nVRST_Tx,
  input  ppu_cfg_pkg::cfg_word_t   cfg_word_i,
  input  logic                     vinfo_pal_i,
  input  logic                     vinfo_480i_i,
  input  logic                     vsync_i,
  input  logic                     hsync_i,
  input  logic                     de_i,
  input  ppu_video_pkg::pixel_t    vdata_i,
  output logic                     vsync_o,
  output logic                     hsync_o,
  output logic                     de_o,
  output ppu_video_pkg::pixel_t    vdata_o,
  output ppu_cfg_pkg::video_mode_e video_mode_o,
  output logic [2:0]               osd_vscale_o,
  output logic [1:0]               osd_hscale_o,
  output logic [10:0]              osd_voffset_o,
  output logic [11:0]              osd_hoffset_o,
  output logic                     active_vsync_o,
  output logic                     active_hsync_o,
  output logic [4:0]               vscale_o,
  output logic [4:0]               hscale_o,
  output logic [1:0]               interp_o,
  output logic                     pal_boxed_o,
  output logic                     llm_o,
  output logic                     limited_rgb_o,
  output logic [7:0]               sl_str_o,
  output logic [4:0]               sl_hyb_o,
  output logic [1:0]               sl_thickness_o,
  output logic                     sl_id_o,
  output logic                     sl_en_o,
  output logic                     sl_method_o
);

  import ppu_video_pkg::*;

  pixel_t limited_pix;  // Compressed pixel
  pixel_t full_dly;     // Untouched pixel, aligned
  sync_t  sync_in, sync_dly;

  assign sync_in = {vsync_i, hsync_i, de_i};

  // ==============================
  // Settings
  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx),
    .cfg_word_i(cfg_word_i), .vinfo_pal_i(vinfo_pal_i), .vinfo_480i_i(vinfo_480i_i),
    .video_mode_o(video_mode_o),
    .osd_vscale_o(osd_vscale_o), .osd_hscale_o(osd_hscale_o),
    .osd_voffset_o(osd_voffset_o), .osd_hoffset_o(osd_hoffset_o),
    .active_vsync_o(active_vsync_o), .active_hsync_o(active_hsync_o),
    .vscale_o(vscale_o), .hscale_o(hscale_o), .interp_o(interp_o),
    .pal_boxed_o(pal_boxed_o), .llm_o(llm_o), .limited_rgb_o(limited_rgb_o),
    .sl_str_o(sl_str_o), .sl_hyb_o(sl_hyb_o), .sl_thickness_o(sl_thickness_o),
    .sl_id_o(sl_id_o), .sl_en_o(sl_en_o), .sl_method_o(sl_method_o)
  );

  // ==============================
  // Video path
  rgb_range_limit u_range_limit (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .pixel_i(vdata_i), .pixel_o(limited_pix)
  );

  video_delay_line #(.DEPTH(PIPE_DEPTH), .payload_t(pixel_t)) u_pix_delay (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .data_i(vdata_i), .data_o(full_dly)
  );

  video_delay_line #(.DEPTH(PIPE_DEPTH), .payload_t(sync_t)) u_sync_delay (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .data_i(sync_in), .data_o(sync_dly)
  );

  ppu_output_stage u_output_stage (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .limited_rgb_i(limited_rgb_o),
    .limited_i(limited_pix), .full_i(full_dly), .sync_i(sync_dly),
    .vsync_o(vsync_o), .hsync_o(hsync_o), .de_o(de_o), .vdata_o(vdata_o)
  );

endmodule

//--- dv/ppu_tx_tb.sv
// PPU transmit side testbench
`timescale 1ns/1ps

module ppu_tx_tb;

  import ppu_cfg_pkg::*;
  import ppu_video_pkg::*;

  localparam int unsigned PIPE_DEPTH   = 2;
  localparam int          NUM_CASES    = 13;
  localparam int          PIX_PER_PASS = 100;                  // Full pass, then limited pass
  localparam int          NUM_PIX      = 2 * PIX_PER_PASS;
  localparam int          CYCLE_LIMIT  = NUM_CASES * 4 + NUM_PIX + 50;

  // One configuration case with the values it must produce
  typedef struct {
    cfg_word_t   cfg;
    logic        pal;
    logic        i480;
    video_mode_e mode;
    logic [2:0]  osd_vs;
    logic [1:0]  osd_hs;
    logic [10:0] voff;
    logic [11:0] hoff;
    logic        sync_lvl;     // Same level for vsync and hsync
    logic [1:0]  thick;
    logic [4:0]  hsc;
    logic [7:0]  str;
    logic [4:0]  hyb;
    logic        id;
    logic        en;
    logic        meth;
  } cfg_case_t;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  cfg_word_t   cfg_word_i;
  logic        vinfo_pal_i;
  logic        vinfo_480i_i;
  logic        vsync_i;
  logic        hsync_i;
  logic        de_i;
  pixel_t      vdata_i;
  logic        vsync_o;
  logic        hsync_o;
  logic        de_o;
  pixel_t      vdata_o;
  video_mode_e video_mode_o;
  logic [2:0]  osd_vscale_o;
  logic [1:0]  osd_hscale_o;
  logic [10:0] osd_voffset_o;
  logic [11:0] osd_hoffset_o;
  logic        active_vsync_o;
  logic        active_hsync_o;
  logic [4:0]  vscale_o;
  logic [4:0]  hscale_o;
  logic [1:0]  interp_o;
  logic        pal_boxed_o;
  logic        llm_o;
  logic        limited_rgb_o;
  logic [7:0]  sl_str_o;
  logic [4:0]  sl_hyb_o;
  logic [1:0]  sl_thickness_o;
  logic        sl_id_o;
  logic        sl_en_o;
  logic        sl_method_o;

  cfg_case_t cases [NUM_CASES];
  int        n_cases;
  int        cycles;
  integer    seed;

  ppu_tx_top #(.PIPE_DEPTH(PIPE_DEPTH)) DUT (.*);

  initial begin
    VCLK_Tx = 1'b0;
    forever #2 VCLK_Tx = ~VCLK_Tx;  // 4 ns period
  end

  // Run length guard
  initial begin
    cycles = 0;
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge VCLK_Tx);
      cycles++;
    end
    $display("Timeout, run still busy after %0d cycles", cycles);
    $display("Test failed");
    $fatal(1, "cycle limit reached");
  end

  // ==============================
  // Checking helpers
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else begin
      $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Fixed scanline fields, only the 480i link bit varies
  task automatic add_case(input target_res_e tgt, input logic vga, input logic f60,
                          input logic f50, input logic llm, input logic link,
                          input logic [4:0] vsc, input logic linked, input logic pal,
                          input logic i480, input video_mode_e mode, input logic [2:0] ovs,
                          input logic [1:0] ohs, input logic [10:0] voff,
                          input logic [11:0] hoff, input logic sync, input logic [1:0] thick);
    cfg_case_t e;
    int        s;
    e.cfg              = '0;
    e.cfg.limited_rgb  = vsc[0];       // Pass-through fields vary per case
    e.cfg.target_res   = tgt;
    e.cfg.vga480p      = vga;
    e.cfg.force60      = f60;
    e.cfg.force50      = f50;
    e.cfg.llm          = llm;
    e.cfg.link_hv      = link;
    e.cfg.vscale       = vsc;
    e.cfg.hscale       = 5'd7;
    e.cfg.interp       = vsc[1:0];
    e.cfg.pal_boxed    = pal;
    e.cfg.sl240_en     = 1'b1;
    e.cfg.sl240_id     = 1'b1;
    e.cfg.sl240_method = 1'b1;
    e.cfg.sl240_str    = 4'd3;
    e.cfg.sl240_hyb    = 5'd10;
    e.cfg.sl480_linked = linked;
    e.cfg.sl480_str    = 4'd9;
    e.cfg.sl480_hyb    = 5'd21;
    e.pal      = pal;
    e.i480     = i480;
    e.mode     = mode;
    e.osd_vs   = ovs;
    e.osd_hs   = ohs;
    e.voff     = voff;
    e.hoff     = hoff;
    e.sync_lvl = sync;
    e.thick    = thick;
    e.hsc      = link ? vsc : 5'd7;
    // 240p set unless interlaced and not linked
    s      = (i480 && !linked) ? 9 : 3;
    e.str  = 8'((s + 1) * 16 - 1);
    e.hyb  = (i480 && !linked) ? 5'd21 : 5'd10;
    e.id   = !(i480 && !linked);
    e.en   = !i480;                      // sl480_en is clear in every case
    e.meth = !i480;
    cases[n_cases] = e;
    n_cases++;
  endtask

  task automatic check_case(input int i);
    string t;
    t = $sformatf("case %0d", i);
    check_val({t, " mode"}, 32'(cases[i].mode), 32'(video_mode_o));
    check_val({t, " osd vscale"}, 32'(cases[i].osd_vs), 32'(osd_vscale_o));
    check_val({t, " osd hscale"}, 32'(cases[i].osd_hs), 32'(osd_hscale_o));
    check_val({t, " osd voffset"}, 32'(cases[i].voff), 32'(osd_voffset_o));
    check_val({t, " osd hoffset"}, 32'(cases[i].hoff), 32'(osd_hoffset_o));
    check_val({t, " vsync level"}, 32'(cases[i].sync_lvl), 32'(active_vsync_o));
    check_val({t, " hsync level"}, 32'(cases[i].sync_lvl), 32'(active_hsync_o));
    check_val({t, " thickness"}, 32'(cases[i].thick), 32'(sl_thickness_o));
    check_val({t, " vscale"}, 32'(cases[i].cfg.vscale), 32'(vscale_o));
    check_val({t, " hscale"}, 32'(cases[i].hsc), 32'(hscale_o));
    check_val({t, " interp"}, 32'(cases[i].cfg.interp), 32'(interp_o));
    check_val({t, " pal boxed"}, 32'(cases[i].cfg.pal_boxed), 32'(pal_boxed_o));
    check_val({t, " llm"}, 32'(cases[i].cfg.llm), 32'(llm_o));
    check_val({t, " limited rgb"}, 32'(cases[i].cfg.limited_rgb), 32'(limited_rgb_o));
    check_val({t, " sl strength"}, 32'(cases[i].str), 32'(sl_str_o));
    check_val({t, " sl hybrid"}, 32'(cases[i].hyb), 32'(sl_hyb_o));
    check_val({t, " sl id"}, 32'(cases[i].id), 32'(sl_id_o));
    check_val({t, " sl enable"}, 32'(cases[i].en), 32'(sl_en_o));
    check_val({t, " sl method"}, 32'(cases[i].meth), 32'(sl_method_o));
  endtask

  // Keep bits 15:7 of c*220, round half up, then add 16
  function automatic logic [7:0] limit_chan(input logic [7:0] c);
    int prod;
    int s;
    prod = int'(c) * 220;
    s    = prod / 128;
    return 8'(s / 2 + s % 2 + 16);
  endfunction

  function automatic pixel_t limit_pix(input pixel_t p);
    pixel_t q;
    q.r = limit_chan(p.r);
    q.g = limit_chan(p.g);
    q.b = limit_chan(p.b);
    return q;
  endfunction

  // One output pixel and its syncs against the model
  task automatic compare_output(input string tag, input int idx, input pixel_t exp_pix,
                                input logic [2:0] exp_sync);
    check_val($sformatf("%s pixel %0d", tag, idx), 32'(exp_pix), 32'(vdata_o));
    check_val($sformatf("%s sync %0d", tag, idx), 32'(exp_sync),
              32'({vsync_o, hsync_o, de_o}));
  endtask

  // Random pixels and syncs, output compared 3 cycles later
  task automatic run_pixels(input logic lim, input string tag);
    pixel_t      exp_q [$];
    logic [2:0]  sync_q [$];
    logic [31:0] rnd;
    pixel_t      pix;
    logic [2:0]  snc;
    cfg_word_t   cfg;
    int          idx;
    cfg = cases[0].cfg;
    cfg.limited_rgb = lim;
    idx = 0;
    @(posedge VCLK_Tx);
    cfg_word_i <= cfg;
    repeat (2) @(posedge VCLK_Tx);    // Let the range select settle
    for (int n = 0; n < PIX_PER_PASS; n++) begin
      @(posedge VCLK_Tx);
      rnd = $random(seed);
      pix = rnd[23:0];
      rnd = $random(seed);
      snc = rnd[2:0];
      vdata_i <= pix;
      vsync_i <= snc[2];
      hsync_i <= snc[1];
      de_i    <= snc[0];
      exp_q.push_back(lim ? limit_pix(pix) : pix);
      sync_q.push_back(snc);
      @(negedge VCLK_Tx);
      if (exp_q.size() == 4) begin     // Oldest entry has reached the output
        compare_output(tag, idx, exp_q.pop_front(), sync_q.pop_front());
        idx++;
      end
    end
    while (exp_q.size() > 0) begin    // Last pixels still in flight
      @(negedge VCLK_Tx);
      compare_output(tag, idx, exp_q.pop_front(), sync_q.pop_front());
      idx++;
    end
  endtask

  // ==============================
  // Main sequence
  initial begin
    seed         = 32'hbb17_cf69;
    n_cases      = 0;
    nVRST_Tx     = 1'b0;
    cfg_word_i   = '0;
    vinfo_pal_i  = 1'b0;
    vinfo_480i_i = 1'b0;
    vsync_i      = 1'b0;
    hsync_i      = 1'b0;
    de_i         = 1'b0;
    vdata_i      = '0;

    // Columns: target, vga, f60, f50, llm, link, vscale, linked, pal, 480i, then expected
    add_case(TGT_480P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd4, 1'b0, 1'b0, 1'b0,
             VM_480P60, 3'd1, 2'd0, 11'd60, 12'd266, 1'b0, 2'd0);
    add_case(TGT_480P, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd6, 1'b0, 1'b0, 1'b0,
             VM_VGA60, 3'd1, 2'd0, 11'd59, 12'd248, 1'b0, 2'd1);
    add_case(TGT_480P, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd13, 1'b0, 1'b1, 1'b0,
             VM_576P50, 3'd1, 2'd0, 11'd88, 12'd276, 1'b0, 2'd1);
    add_case(TGT_720P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd14, 1'b0, 1'b0, 1'b1,
             VM_720P60, 3'd2, 2'd1, 11'd50, 12'd234, 1'b1, 2'd2);
    add_case(TGT_720P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd5, 1'b0, 1'b1, 1'b0,
             VM_720P50, 3'd2, 2'd1, 11'd50, 12'd234, 1'b1, 2'd0);
    add_case(TGT_960P, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd8, 1'b0, 1'b0, 1'b0,
             VM_960P50, 3'd3, 2'd1, 11'd48, 12'd160, 1'b1, 2'd1);
    add_case(TGT_1080P, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 5'd9, 1'b0, 1'b1, 1'b0,
             VM_1080P60, 3'd4, 2'd2, 11'd38, 12'd168, 1'b1, 2'd1);
    add_case(TGT_1080P, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 5'd31, 1'b0, 1'b1, 1'b0,
             VM_1080P50, 3'd3, 2'd2, 11'd67, 12'd168, 1'b1, 2'd2);
    add_case(TGT_1200P, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 5'd20, 1'b0, 1'b0, 1'b0,
             VM_1200P60, 3'd4, 2'd2, 11'd48, 12'd88, 1'b1, 2'd2);
    add_case(TGT_1200P, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 5'd12, 1'b0, 1'b0, 1'b1,
             VM_1200P50, 3'd4, 2'd2, 11'd48, 12'd88, 1'b1, 2'd1);
    add_case(TGT_960P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd7, 1'b1, 1'b0, 1'b1,
             VM_960P60, 3'd3, 2'd1, 11'd48, 12'd160, 1'b1, 2'd1);
    add_case(TGT_1080P, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0, 1'b0,
             VM_1080P60, 3'd4, 2'd2, 11'd38, 12'd168, 1'b1, 2'd0);
    add_case(TGT_480P, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 5'd3, 1'b0, 1'b0, 1'b0,
             VM_576P50, 3'd1, 2'd0, 11'd88, 12'd276, 1'b0, 2'd0);

    @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
    check_val("reset mode", 32'(VM_480P60), 32'(video_mode_o));
    check_val("reset de", 32'd0, 32'(de_o));
    check_val("reset pixel", 32'd0, 32'(vdata_o));
    @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;

    // Settings decode
    for (int i = 0; i < NUM_CASES; i++) begin
      @(posedge VCLK_Tx);
      cfg_word_i   <= cases[i].cfg;
      vinfo_pal_i  <= cases[i].pal;
      vinfo_480i_i <= cases[i].i480;
      repeat (3) @(negedge VCLK_Tx);   // Two-stage outputs have settled
      check_case(i);
    end

    run_pixels(1'b0, "full");
    run_pixels(1'b1, "limited");

    $display("Test passed");
    $finish;
  end

endmodule

//--- ppu_tx_top.f
verilog/ppu_cfg_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_cfg_decode.sv
verilog/rgb_range_limit.sv
verilog/video_delay_line.sv
verilog/ppu_output_stage.sv
verilog/ppu_tx_top.sv
dv/ppu_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := ppu_tx_tb
FILELIST  := ppu_tx_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
